//--- hw/cache_macros.svh
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// byte address and line geometry
`define CACHE_ADDR_WIDTH 12
`define CACHE_NUM_LINES 8
`define CACHE_LINE_BYTES 16
`define CACHE_WORD_BYTES 4

// field widths inside a byte address
`define CACHE_LANE_WIDTH ($clog2(`CACHE_WORD_BYTES))
`define CACHE_OFFSET_WIDTH ($clog2(`CACHE_LINE_BYTES))
`define CACHE_INDEX_WIDTH ($clog2(`CACHE_NUM_LINES))
`define CACHE_LINE_ADDR_WIDTH (`CACHE_ADDR_WIDTH - `CACHE_OFFSET_WIDTH)
`define CACHE_TAG_WIDTH (`CACHE_LINE_ADDR_WIDTH - `CACHE_INDEX_WIDTH)

// data widths in bits
`define CACHE_WORD_WIDTH (8 * `CACHE_WORD_BYTES)
`define CACHE_LINE_WIDTH (8 * `CACHE_LINE_BYTES)

// store buffer entries
`define CACHE_SB_DEPTH 4

// cycles from a line read request to its response
`define CACHE_MEM_LATENCY 4

`endif

//--- hw/cache_pkg.sv
`default_nettype none

`include "cache_macros.svh"

package cache_pkg;

    typedef enum logic [1:0] {
        BYTE,
        HALF,
        WORD
    } access_mode_e;

    // REQUESTED means a fill is in flight for the stored tag
    typedef enum logic [1:0] {
        INVALID,
        VALID,
        REQUESTED
    } line_state_e;

    // requester side, held until hit
    typedef struct packed {
        logic                          read;
        logic                          write;
        access_mode_e                  mode;
        logic [`CACHE_ADDR_WIDTH-1:0]  addr;
        logic [`CACHE_WORD_WIDTH-1:0]  data;
    } cache_request_t;

    typedef struct packed {
        logic                          hit;
        logic [`CACHE_WORD_WIDTH-1:0]  data;
    } cache_response_t;

    typedef struct packed {
        logic                              read;
        logic                              write;
        logic [`CACHE_LINE_ADDR_WIDTH-1:0] addr;
        logic [`CACHE_LINE_WIDTH-1:0]      data;
    } mem_request_t;

    typedef struct packed {
        logic                              valid;
        logic [`CACHE_LINE_ADDR_WIDTH-1:0] addr;
        logic [`CACHE_LINE_WIDTH-1:0]      data;
    } mem_response_t;

    // data already sits in the byte lanes given by mask
    typedef struct packed {
        logic [`CACHE_ADDR_WIDTH-1:0]  addr;
        logic [`CACHE_WORD_BYTES-1:0]  mask;
        logic [`CACHE_WORD_WIDTH-1:0]  data;
    } store_entry_t;

endpackage

`default_nettype wire

//--- hw/store_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module store_buffer (
    input  wire logic                          clock,
    input  wire logic                          reset,
    input  wire logic                          push,
    input  wire cache_pkg::store_entry_t       push_entry,
    input  wire logic                          pop,
    output cache_pkg::store_entry_t            pop_entry,
    output logic                               empty,
    output logic                               full,
    input  wire logic [`CACHE_ADDR_WIDTH-1:0]  lookup_addr,
    output logic [`CACHE_NUM_LINES-1:0]        hit_lines,
    output logic [`CACHE_WORD_BYTES-1:0]       hit_bytes,
    output logic [`CACHE_WORD_WIDTH-1:0]       forward_data
);

    localparam int PTR_WIDTH = $clog2(`CACHE_SB_DEPTH);
    localparam int COUNT_WIDTH = PTR_WIDTH + 1;

    cache_pkg::store_entry_t entries [`CACHE_SB_DEPTH];

    logic [PTR_WIDTH-1:0]   head;
    logic [PTR_WIDTH-1:0]   tail;
    logic [COUNT_WIDTH-1:0] count;

    assign empty = count == '0;
    assign full = count == COUNT_WIDTH'(`CACHE_SB_DEPTH);
    assign pop_entry = entries[head];

    always_ff @(posedge clock) begin
        if (reset) begin
            head <= '0;
            tail <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= tail + 1'b1;
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            count <= count + COUNT_WIDTH'(push) - COUNT_WIDTH'(pop);
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            entries[tail] <= push_entry;
        end
    end

    // walk from oldest to youngest so the youngest store owns each byte
    always_comb begin
        logic [PTR_WIDTH-1:0] slot;

        hit_lines = '0;
        hit_bytes = '0;
        forward_data = '0;
        for (int k = 0; k < `CACHE_SB_DEPTH; k++) begin
            slot = head + PTR_WIDTH'(k);
            if (k < count) begin
                hit_lines[entries[slot].addr[`CACHE_OFFSET_WIDTH +: `CACHE_INDEX_WIDTH]] = 1'b1;
                if (entries[slot].addr[`CACHE_ADDR_WIDTH-1:`CACHE_LANE_WIDTH] ==
                        lookup_addr[`CACHE_ADDR_WIDTH-1:`CACHE_LANE_WIDTH]) begin
                    for (int b = 0; b < `CACHE_WORD_BYTES; b++) begin
                        if (entries[slot].mask[b]) begin
                            hit_bytes[b] = 1'b1;
                            forward_data[8*b +: 8] = entries[slot].data[8*b +: 8];
                        end
                    end
                end
            end
        end
    end

    // the cache must hold a write back while full
    push_not_full: assert property (@(posedge clock) disable iff (reset)
        push |-> !full);

    pop_not_empty: assert property (@(posedge clock) disable iff (reset)
        pop |-> !empty);

endmodule

`default_nettype wire

//--- hw/data_cache.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module data_cache (
    input  wire logic                      clock,
    input  wire logic                      reset,
    input  wire cache_pkg::cache_request_t cache_request,
    input  wire logic                      mem_available,
    input  wire cache_pkg::mem_response_t  mem_response,
    output cache_pkg::cache_response_t     cache_response,
    output cache_pkg::mem_request_t        mem_request
);

    localparam int WORD_SEL_WIDTH = `CACHE_OFFSET_WIDTH - `CACHE_LANE_WIDTH;

    // per-line storage
    cache_pkg::line_state_e        line_state [`CACHE_NUM_LINES];
    logic [`CACHE_TAG_WIDTH-1:0]   line_tag   [`CACHE_NUM_LINES];
    logic [`CACHE_LINE_BYTES-1:0]  line_dirty [`CACHE_NUM_LINES];
    logic [`CACHE_LINE_WIDTH-1:0]  line_data  [`CACHE_NUM_LINES];

    logic [`CACHE_TAG_WIDTH-1:0]   req_tag;
    logic [`CACHE_INDEX_WIDTH-1:0] req_index;
    logic [WORD_SEL_WIDTH-1:0]     req_word;
    logic [`CACHE_LANE_WIDTH-1:0]  req_lane;

    cache_pkg::line_state_e state;
    logic tag_match;
    logic access;
    logic read_hit;
    logic write_hit;
    logic victim_dirty;
    logic need_line;

    assign {req_tag, req_index, req_word, req_lane} = cache_request.addr;
    assign state = line_state[req_index];
    assign tag_match = line_tag[req_index] == req_tag;
    assign access = cache_request.read || cache_request.write;

    // bytes touched by the access, before and after moving to its lane
    logic [`CACHE_WORD_BYTES-1:0] size_mask;
    logic [`CACHE_WORD_BYTES-1:0] req_mask;

    always_comb begin
        case (cache_request.mode)
            cache_pkg::BYTE: size_mask = `CACHE_WORD_BYTES'(1);
            cache_pkg::HALF: size_mask = `CACHE_WORD_BYTES'(3);
            default:         size_mask = '1;
        endcase
    end

    assign req_mask = size_mask << req_lane;

    // store buffer
    cache_pkg::store_entry_t       push_entry;
    cache_pkg::store_entry_t       pop_entry;
    logic                          sb_pop;
    logic                          sb_empty;
    logic                          sb_full;
    logic [`CACHE_NUM_LINES-1:0]   sb_hit_lines;
    logic [`CACHE_WORD_BYTES-1:0]  sb_hit_bytes;
    logic [`CACHE_WORD_WIDTH-1:0]  sb_data;

    assign push_entry.addr = cache_request.addr;
    assign push_entry.mask = req_mask;
    assign push_entry.data = cache_request.data << {req_lane, 3'b000};

    // drain every cycle except when a fill owns the array
    assign sb_pop = !sb_empty && !mem_response.valid;

    store_buffer i_store_buffer (
        .clock        (clock),
        .reset        (reset),
        .push         (write_hit),
        .push_entry   (push_entry),
        .pop          (sb_pop),
        .pop_entry    (pop_entry),
        .empty        (sb_empty),
        .full         (sb_full),
        .lookup_addr  (cache_request.addr),
        .hit_lines    (sb_hit_lines),
        .hit_bytes    (sb_hit_bytes),
        .forward_data (sb_data)
    );

    // read path
    logic [`CACHE_WORD_WIDTH-1:0] array_word;
    logic [`CACHE_WORD_WIDTH-1:0] merged_word;
    logic [`CACHE_WORD_WIDTH-1:0] shifted_word;
    logic [`CACHE_WORD_WIDTH-1:0] read_word;
    logic [`CACHE_WORD_BYTES-1:0] array_bytes;
    logic [`CACHE_WORD_BYTES-1:0] usable_bytes;

    assign array_word = line_data[req_index][req_word*`CACHE_WORD_WIDTH +: `CACHE_WORD_WIDTH];

    // a pending line only has the bytes already stored into it
    always_comb begin
        array_bytes = '0;
        if (tag_match && state == cache_pkg::VALID) begin
            array_bytes = '1;
        end else if (tag_match && state == cache_pkg::REQUESTED) begin
            array_bytes = line_dirty[req_index][req_word*`CACHE_WORD_BYTES +: `CACHE_WORD_BYTES];
        end
    end

    assign usable_bytes = array_bytes | sb_hit_bytes;

    for (genvar b = 0; b < `CACHE_WORD_BYTES; b++) begin : gen_bytes
        assign merged_word[8*b +: 8] = sb_hit_bytes[b] ? sb_data[8*b +: 8]
                                                       : array_word[8*b +: 8];
        assign read_word[8*b +: 8] = size_mask[b] ? shifted_word[8*b +: 8] : 8'h00;
    end

    assign shifted_word = merged_word >> {req_lane, 3'b000};

    assign read_hit = cache_request.read && (req_mask & ~usable_bytes) == '0;
    assign write_hit = cache_request.write && state != cache_pkg::INVALID && tag_match
                       && !sb_full;

    assign cache_response.hit = read_hit || write_hit;
    assign cache_response.data = read_word;

    // miss handling, a victim with stores still queued stays put
    assign victim_dirty = state == cache_pkg::VALID && |line_dirty[req_index];
    assign need_line = access && !sb_hit_lines[req_index]
                       && (state == cache_pkg::INVALID || (state == cache_pkg::VALID && !tag_match));

    assign mem_request.read = mem_available && need_line && !victim_dirty;
    assign mem_request.write = mem_available && need_line && victim_dirty;
    assign mem_request.addr = victim_dirty ? {line_tag[req_index], req_index}
                                           : {req_tag, req_index};
    assign mem_request.data = line_data[req_index];

    logic [`CACHE_INDEX_WIDTH-1:0] fill_index;
    logic [`CACHE_INDEX_WIDTH-1:0] drain_index;
    logic [WORD_SEL_WIDTH-1:0]     drain_word;

    assign fill_index = mem_response.addr[`CACHE_INDEX_WIDTH-1:0];
    assign {drain_index, drain_word} =
        pop_entry.addr[`CACHE_LANE_WIDTH +: `CACHE_INDEX_WIDTH + WORD_SEL_WIDTH];

    // line state and dirty masks
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `CACHE_NUM_LINES; i++) begin
                line_state[i] <= cache_pkg::INVALID;
                line_dirty[i] <= '0;
            end
        end else begin
            if (mem_request.read) begin
                line_state[req_index] <= cache_pkg::REQUESTED;
            end else if (mem_request.write) begin
                line_state[req_index] <= cache_pkg::INVALID;
                line_dirty[req_index] <= '0;
            end
            // bytes stored during the fill stay dirty for the next eviction
            if (mem_response.valid) begin
                line_state[fill_index] <= cache_pkg::VALID;
            end
            if (sb_pop) begin
                for (int b = 0; b < `CACHE_WORD_BYTES; b++) begin
                    if (pop_entry.mask[b]) begin
                        line_dirty[drain_index][drain_word*`CACHE_WORD_BYTES + b] <= 1'b1;
                    end
                end
            end
        end
    end

    // tags and line data
    always_ff @(posedge clock) begin
        if (mem_request.read) begin
            line_tag[req_index] <= req_tag;
        end
        if (mem_response.valid) begin
            for (int i = 0; i < `CACHE_LINE_BYTES; i++) begin
                if (!line_dirty[fill_index][i]) begin
                    line_data[fill_index][8*i +: 8] <= mem_response.data[8*i +: 8];
                end
            end
        end
        if (sb_pop) begin
            for (int b = 0; b < `CACHE_WORD_BYTES; b++) begin
                if (pop_entry.mask[b]) begin
                    line_data[drain_index][(drain_word*`CACHE_WORD_BYTES + b)*8 +: 8] <=
                        pop_entry.data[8*b +: 8];
                end
            end
        end
    end

    read_write_exclusive: assert property (@(posedge clock) disable iff (reset)
        !(cache_request.read && cache_request.write));

    access_aligned: assert property (@(posedge clock) disable iff (reset)
        access |-> !(cache_request.mode == cache_pkg::HALF && req_lane[0])
                && !(cache_request.mode == cache_pkg::WORD && req_lane != '0));

    // the memory answers only lines that asked for a fill
    fill_was_requested: assert property (@(posedge clock) disable iff (reset)
        mem_response.valid |-> line_state[fill_index] == cache_pkg::REQUESTED);

endmodule

`default_nettype wire

//--- hw/line_memory.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module line_memory (
    input  wire logic                     clock,
    input  wire logic                     reset,
    input  wire cache_pkg::mem_request_t  mem_request,
    output logic                          mem_available,
    output cache_pkg::mem_response_t      mem_response
);

    localparam int NUM_MEM_LINES = 1 << `CACHE_LINE_ADDR_WIDTH;
    localparam int COUNT_WIDTH = $clog2(`CACHE_MEM_LATENCY + 1);

    logic [`CACHE_LINE_WIDTH-1:0]      lines [NUM_MEM_LINES];
    logic [COUNT_WIDTH-1:0]            countdown;
    logic [`CACHE_LINE_ADDR_WIDTH-1:0] pending_addr;

    // busy from the cycle after a read request through its response
    assign mem_available = countdown == '0;
    assign mem_response.valid = countdown == COUNT_WIDTH'(1);
    assign mem_response.addr = pending_addr;
    assign mem_response.data = lines[pending_addr];

    always_ff @(posedge clock) begin
        if (reset) begin
            countdown <= '0;
            // fixed pattern, byte at address a holds 7a + 3
            for (int l = 0; l < NUM_MEM_LINES; l++) begin
                for (int b = 0; b < `CACHE_LINE_BYTES; b++) begin
                    lines[l][8*b +: 8] <= 8'(7 * (l * `CACHE_LINE_BYTES + b) + 3);
                end
            end
        end else begin
            if (mem_request.read) begin
                countdown <= COUNT_WIDTH'(`CACHE_MEM_LATENCY);
            end else if (countdown != '0) begin
                countdown <= countdown - 1'b1;
            end
            if (mem_request.write) begin
                lines[mem_request.addr] <= mem_request.data;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (mem_request.read) begin
            pending_addr <= mem_request.addr;
        end
    end

endmodule

`default_nettype wire

//--- hw/cache_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module cache_subsystem (
    input  wire logic                      clock,
    input  wire logic                      reset,
    input  wire cache_pkg::cache_request_t cache_request,
    output cache_pkg::cache_response_t     cache_response
);

    cache_pkg::mem_request_t  mem_request;
    cache_pkg::mem_response_t mem_response;
    logic                     mem_available;

    data_cache i_data_cache (
        .clock          (clock),
        .reset          (reset),
        .cache_request  (cache_request),
        .mem_available  (mem_available),
        .mem_response   (mem_response),
        .cache_response (cache_response),
        .mem_request    (mem_request)
    );

    // backing store, whole lines only
    line_memory i_line_memory (
        .clock         (clock),
        .reset         (reset),
        .mem_request   (mem_request),
        .mem_available (mem_available),
        .mem_response  (mem_response)
    );

endmodule

`default_nettype wire

//--- verification/clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
    parameter int PERIOD_NS = 40
) (
    output logic clock
);

    // starts low, first rising edge at half a period
    always begin
        clock = 1'b0;
        #(PERIOD_NS / 2);
        clock = 1'b1;
        #(PERIOD_NS / 2);
    end

endmodule

`default_nettype wire

//--- verification/cache_subsystem_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module cache_subsystem_tb;

    localparam int NUM_DIRECTED = 31;
    localparam int NUM_RANDOM = 300;
    localparam int NUM_OPS = NUM_DIRECTED + NUM_RANDOM;
    // worst access needs a write-back, a full drain and one fill
    localparam int TIMEOUT_CYCLES =
        NUM_OPS * (3 * `CACHE_MEM_LATENCY + `CACHE_SB_DEPTH + 4) + 50;
    localparam int MEM_BYTES = 1 << `CACHE_ADDR_WIDTH;

    logic clock;
    logic reset;
    cache_pkg::cache_request_t  cache_request;
    cache_pkg::cache_response_t cache_response;

    // byte-level reference of the backing memory
    logic [7:0]                   model_mem [MEM_BYTES];
    logic [`CACHE_WORD_WIDTH-1:0] expected;
    int     errors = 0;
    int     reads_checked = 0;
    int     writes_applied = 0;
    int     cycle_count;
    integer seed = 12;

    clock_gen #(.PERIOD_NS(40)) i_clock_gen (.clock(clock));

    cache_subsystem i_cache_subsystem (
        .clock          (clock),
        .reset          (reset),
        .cache_request  (cache_request),
        .cache_response (cache_response)
    );

    function automatic int size_in_bytes(input cache_pkg::access_mode_e mode);
        case (mode)
            cache_pkg::BYTE: return 1;
            cache_pkg::HALF: return 2;
            default:         return 4;
        endcase
    endfunction

    // zero-extended bytes from the model with low lanes first
    function automatic logic [`CACHE_WORD_WIDTH-1:0] expected_read(
        input logic [`CACHE_ADDR_WIDTH-1:0] addr,
        input cache_pkg::access_mode_e      mode
    );
        logic [`CACHE_WORD_WIDTH-1:0] value;
        logic [`CACHE_ADDR_WIDTH-1:0] byte_addr;

        value = '0;
        for (int i = 0; i < size_in_bytes(mode); i++) begin
            byte_addr = addr + `CACHE_ADDR_WIDTH'(i);
            value[8*i +: 8] = model_mem[byte_addr];
        end
        return value;
    endfunction

    function automatic void store_bytes(
        input logic [`CACHE_ADDR_WIDTH-1:0] addr,
        input cache_pkg::access_mode_e      mode,
        input logic [`CACHE_WORD_WIDTH-1:0] data
    );
        logic [`CACHE_ADDR_WIDTH-1:0] byte_addr;

        for (int i = 0; i < size_in_bytes(mode); i++) begin
            byte_addr = addr + `CACHE_ADDR_WIDTH'(i);
            model_mem[byte_addr] = data[8*i +: 8];
        end
    endfunction

    // keep only the lanes a write of this size uses
    function automatic logic [`CACHE_WORD_WIDTH-1:0] low_lanes(
        input logic [`CACHE_WORD_WIDTH-1:0] data,
        input cache_pkg::access_mode_e      mode
    );
        case (mode)
            cache_pkg::BYTE: return {24'h000000, data[7:0]};
            cache_pkg::HALF: return {16'h0000, data[15:0]};
            default:         return data;
        endcase
    endfunction

    task automatic hold_request(input cache_pkg::cache_request_t req);
        @(posedge clock);
        cache_request <= req;
        @(negedge clock);
        while (cache_response.hit !== 1'b1) begin
            @(negedge clock);
        end
    endtask

    task automatic read_at(
        input cache_pkg::access_mode_e      mode,
        input logic [`CACHE_ADDR_WIDTH-1:0] addr
    );
        cache_pkg::cache_request_t req;

        req = '0;
        req.read = 1'b1;
        req.mode = mode;
        req.addr = addr;
        hold_request(req);
    endtask

    task automatic write_at(
        input cache_pkg::access_mode_e      mode,
        input logic [`CACHE_ADDR_WIDTH-1:0] addr,
        input logic [`CACHE_WORD_WIDTH-1:0] data
    );
        cache_pkg::cache_request_t req;

        req = '0;
        req.write = 1'b1;
        req.mode = mode;
        req.addr = addr;
        req.data = data;
        hold_request(req);
    endtask

    task automatic random_access();
        logic [31:0]                  rnd_ctrl;
        logic [31:0]                  rnd_addr;
        logic [31:0]                  rnd_data;
        logic [`CACHE_ADDR_WIDTH-1:0] addr;
        cache_pkg::access_mode_e      mode;

        rnd_ctrl = $random(seed);
        rnd_addr = $random(seed);
        rnd_data = $random(seed);
        case (rnd_ctrl % 32'd3)
            32'd0:   mode = cache_pkg::BYTE;
            32'd1:   mode = cache_pkg::HALF;
            default: mode = cache_pkg::WORD;
        endcase
        // aligned addresses within 64 lines of 16 bytes
        addr = `CACHE_ADDR_WIDTH'(rnd_addr[9:0]);
        if (mode == cache_pkg::HALF) begin
            addr[0] = 1'b0;
        end
        if (mode == cache_pkg::WORD) begin
            addr[1:0] = 2'b00;
        end
        if (rnd_ctrl[16]) begin
            write_at(mode, addr, low_lanes(rnd_data, mode));
        end else begin
            read_at(mode, addr);
        end
    endtask

    // every hit cycle completes one access
    always @(negedge clock) begin
        if (!reset && cache_response.hit) begin
            if (cache_request.read) begin
                expected = expected_read(cache_request.addr, cache_request.mode);
                reads_checked++;
                if (cache_response.data !== expected) begin
                    errors++;
                    $display("** Error: cache_response.data = %h, expected %h, addr %h",
                             cache_response.data, expected, cache_request.addr);
                end
            end else if (cache_request.write) begin
                store_bytes(cache_request.addr, cache_request.mode, cache_request.data);
                writes_applied++;
            end else begin
                errors++;
                $display("** Error: cache_response.hit = %h with no request, expected 0",
                         cache_response.hit);
            end
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("timeout: accesses still waiting for hit after %0d cycles", TIMEOUT_CYCLES);
        $display("errors: %0d, reads checked: %0d, writes applied: %0d",
                 errors, reads_checked, writes_applied);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        cache_request <= '0;
        reset <= 1'b1;
        for (int a = 0; a < MEM_BYTES; a++) begin
            model_mem[`CACHE_ADDR_WIDTH'(a)] = 8'(7 * a + 3);
        end
        repeat (3) @(posedge clock);
        reset <= 1'b0;

        // hit must stay low while idle
        repeat (5) @(posedge clock);

        // cold reads of the initial pattern
        read_at(cache_pkg::WORD, 12'h000);
        read_at(cache_pkg::WORD, 12'h014);
        read_at(cache_pkg::WORD, 12'h0a8);
        read_at(cache_pkg::WORD, 12'h3fc);

        // every lane of one word
        read_at(cache_pkg::BYTE, 12'h124);
        read_at(cache_pkg::BYTE, 12'h125);
        read_at(cache_pkg::BYTE, 12'h126);
        read_at(cache_pkg::BYTE, 12'h127);
        read_at(cache_pkg::HALF, 12'h124);
        read_at(cache_pkg::HALF, 12'h126);
        read_at(cache_pkg::WORD, 12'h124);

        // forwarding from the store buffer and merging with old bytes
        write_at(cache_pkg::WORD, 12'h200, 32'h11223344);
        read_at(cache_pkg::WORD, 12'h200);
        write_at(cache_pkg::BYTE, 12'h201, 32'h000000a5);
        read_at(cache_pkg::WORD, 12'h200);
        write_at(cache_pkg::HALF, 12'h202, 32'h0000beef);
        read_at(cache_pkg::HALF, 12'h202);
        read_at(cache_pkg::WORD, 12'h200);
        write_at(cache_pkg::BYTE, 12'h217, 32'h0000003c);
        read_at(cache_pkg::WORD, 12'h214);

        // dirty victims of an index 0 conflict go back to memory
        write_at(cache_pkg::WORD, 12'h300, 32'hcafef00d);
        write_at(cache_pkg::BYTE, 12'h30d, 32'h00000077);
        read_at(cache_pkg::WORD, 12'h380);
        read_at(cache_pkg::WORD, 12'h300);
        read_at(cache_pkg::WORD, 12'h30c);

        // stores into a line while its fill is in flight
        write_at(cache_pkg::WORD, 12'h524, 32'ha1b2c3d4);
        read_at(cache_pkg::WORD, 12'h524);
        write_at(cache_pkg::BYTE, 12'h529, 32'h0000005e);
        read_at(cache_pkg::WORD, 12'h528);
        read_at(cache_pkg::WORD, 12'h524);
        read_at(cache_pkg::HALF, 12'h52a);

        for (int n = 0; n < NUM_RANDOM; n++) begin
            random_access();
        end

        @(posedge clock);
        cache_request <= '0;
        repeat (4) @(posedge clock);

        $display("errors: %0d, reads checked: %0d, writes applied: %0d",
                 errors, reads_checked, writes_applied);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- cache_subsystem.f
+incdir+hw
hw/cache_pkg.sv
hw/store_buffer.sv
hw/data_cache.sv
hw/line_memory.sv
hw/cache_subsystem.sv
verification/clock_gen.sv
verification/cache_subsystem_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the cache subsystem testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module cache_subsystem_tb \
    -f cache_subsystem.f || exit 1

sim_output=$(./obj_dir/Vcache_subsystem_tb)
echo "$sim_output"

echo "$sim_output" | grep -q "TESTS PASSED" && exit 0 || exit 1
